// File: build.f
source/dma_pkg.sv
source/dma_reg_frontend.sv
source/dma_addr_gen.sv
source/dma_copy_engine.sv
source/dmac_top.sv
tb/tb_clock_gen.sv
tb/tb_mem_model.sv
tb/tb_dmac_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the DMA controller testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_dmac_top -f build.f -o sim_dmac \
  && ./obj_dir/sim_dmac | tee sim.log \
  && grep -q "ALL TESTS PASSED" sim.log \
  && echo "simulation result: pass" \
  || { echo "simulation result: fail, see sim.log"; exit 1; }
exit 0

// File: tb/tb_dmac_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dmac_top import dma_pkg::*; ();

  localparam int unsigned MEM_WORDS       = 1024;
  localparam int unsigned TOTAL_WORDS     = 16 + 12 + 8 + 8;
  localparam int unsigned WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 2000;
  localparam int unsigned WAIT_LIMIT      = 400;

  logic        clk;
  logic        rst_n;
  ctrl_req_t   ctrl_req;
  ctrl_rsp_t   ctrl_rsp;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  logic        term_event;
  logic        busy;
  logic        rd_granted;
  logic [31:0] ref_mem [MEM_WORDS];
  logic [31:0] last_id;
  logic [31:0] expected_id;
  logic [31:0] rd_val;
  int unsigned term_count;
  int unsigned term_before;
  int unsigned error_count;
  int unsigned term_errs;
  int unsigned rvalid_errs;
  int unsigned gnt_errs;
  int unsigned hold_errs;
  int unsigned check_count;
  int unsigned test_count;
  int unsigned failed_tests;
  int unsigned test_err_start;

  tb_clock_gen clock_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  dmac_top dmac_top_inst (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .ctrl_req_i   ( ctrl_req   ),
    .ctrl_rsp_o   ( ctrl_rsp   ),
    .mem_req_o    ( mem_req    ),
    .mem_rsp_i    ( mem_rsp    ),
    .term_event_o ( term_event ),
    .busy_o       ( busy       )
  );

  tb_mem_model mem_model (
    .clk_i     ( clk     ),
    .rst_n_i   ( rst_n   ),
    .mem_req_i ( mem_req ),
    .mem_rsp_o ( mem_rsp )
  );

  // ------------------------------------------------------------------------
  // Protocol checks
  // ------------------------------------------------------------------------

  assign rd_granted = ctrl_req.req && !ctrl_req.we && ctrl_rsp.gnt;

  term_pulse_check: assert property (@(posedge clk) disable iff (!rst_n)
    term_event |=> !term_event)
    else begin
      $display("ERROR term_event_o stayed high for more than one cycle at %0t", $time);
      term_errs++;
    end

  ctrl_gnt_check: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_req.req |-> ctrl_rsp.gnt)
    else begin
      $display("ERROR control request not granted in its own cycle at %0t", $time);
      gnt_errs++;
    end

  rvalid_timing_check: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_rsp.rvalid == $past(rd_granted))
    else begin
      $display("ERROR ctrl rvalid not exactly one cycle after a granted read at %0t", $time);
      rvalid_errs++;
    end

  mem_hold_check: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req.req && !mem_rsp.gnt) |=> (mem_req.req && $stable(mem_req.we)
      && $stable(mem_req.addr) && (!mem_req.we || $stable(mem_req.wdata))))
    else begin
      $display("ERROR memory request changed while waiting for grant at %0t", $time);
      hold_errs++;
    end

  always @(posedge clk) begin
    if (rst_n && term_event) begin
      term_count <= term_count + 1;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------

  function automatic int unsigned total_errors();
    return error_count + term_errs + gnt_errs + rvalid_errs + hold_errs;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic reg_write(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    @(negedge clk);
    ctrl_req.req   = 1'b1;
    ctrl_req.we    = 1'b1;
    ctrl_req.addr  = addr;
    ctrl_req.wdata = data;
    @(negedge clk);
    ctrl_req = '0;
  endtask

  // Data is taken one cycle after the grant
  task automatic reg_read(input logic [REG_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
    @(negedge clk);
    ctrl_req.req   = 1'b1;
    ctrl_req.we    = 1'b0;
    ctrl_req.addr  = addr;
    ctrl_req.wdata = '0;
    @(negedge clk);
    ctrl_req = '0;
    data     = ctrl_rsp.rdata;
  endtask

  task automatic check_reg(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [31:0] exp,
                           input string name);
    logic [31:0] data;
    reg_read(addr, data);
    check_value(name, data, exp);
  endtask

  // Expected memory after the copy by the row and word walk rule
  task automatic predict_copy(input logic [31:0] src, dst, num_bytes,
                              input logic [31:0] src_stride, dst_stride, num_reps);
    int unsigned rows;
    int unsigned r;
    int unsigned k;
    logic [31:0] s_addr;
    logic [31:0] d_addr;
    for (k = 0; k < MEM_WORDS; k++) begin
      ref_mem[k] = mem_model.mem[k];
    end
    rows = (num_reps == 32'h0) ? 1 : num_reps;
    for (r = 0; r < rows; r++) begin
      for (k = 0; k < num_bytes / 4; k++) begin
        s_addr = src + r * src_stride + 4 * k;
        d_addr = dst + r * dst_stride + 4 * k;
        ref_mem[d_addr[11:2]] = ref_mem[s_addr[11:2]];
      end
    end
  endtask

  task automatic compare_memory();
    int unsigned i;
    for (i = 0; i < MEM_WORDS; i++) begin
      check_value($sformatf("mem[0x%03h]", i * 4), mem_model.mem[i], ref_mem[i]);
    end
  endtask

  task automatic start_copy(input logic [31:0] src, dst, num_bytes,
                            input logic [31:0] src_stride, dst_stride, num_reps);
    reg_write(REG_SRC, src);
    reg_write(REG_DST, dst);
    reg_write(REG_NUM_BYTES, num_bytes);
    reg_write(REG_SRC_STRIDE, src_stride);
    reg_write(REG_DST_STRIDE, dst_stride);
    reg_write(REG_NUM_REPS, num_reps);
    predict_copy(src, dst, num_bytes, src_stride, dst_stride, num_reps);
    term_before = term_count;
    reg_read(REG_NEXT_ID, last_id);
    check_value("REG_NEXT_ID", last_id, expected_id);
    expected_id = expected_id + 32'h1;
  endtask

  task automatic finish_copy();
    int unsigned cycles;
    logic [31:0] done_id;
    cycles = 0;
    while (term_count == term_before && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (term_count == term_before) begin
      $display("ERROR transfer %0d never raised term_event_o", last_id);
      error_count++;
    end
    // A few quiet cycles to catch a second pulse
    repeat (4) @(negedge clk);
    check_value("term_event_o count", term_count - term_before, 32'h1);
    check_value("busy_o", 32'(busy), 32'h0);
    reg_read(REG_DONE, done_id);
    check_value("REG_DONE", done_id, expected_id - 32'h1);
    compare_memory();
  endtask

  task automatic begin_test();
    test_err_start = total_errors();
  endtask

  task automatic end_test(input string name);
    int unsigned errs;
    errs = total_errors() - test_err_start;
    test_count++;
    if (errs != 0) begin
      failed_tests++;
    end
    $display("test %0d %s: %0d errors", test_count, name, errs);
  endtask

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------

  initial begin
    ctrl_req    = '0;
    expected_id = 32'h1;
    wait (rst_n === 1'b1);
    @(negedge clk);

    begin_test();
    check_value("busy_o", 32'(busy), 32'h0);
    check_value("term_event_o", 32'(term_event), 32'h0);
    check_value("mem_req_o.req", 32'(mem_req.req), 32'h0);
    check_reg(REG_SRC, 32'h0, "REG_SRC");
    check_reg(REG_DST, 32'h0, "REG_DST");
    check_reg(REG_NUM_BYTES, 32'h0, "REG_NUM_BYTES");
    check_reg(REG_SRC_STRIDE, 32'h0, "REG_SRC_STRIDE");
    check_reg(REG_DST_STRIDE, 32'h0, "REG_DST_STRIDE");
    check_reg(REG_NUM_REPS, 32'h0, "REG_NUM_REPS");
    check_reg(REG_DONE, 32'h0, "REG_DONE");
    check_reg(REG_STATUS, 32'h0, "REG_STATUS");
    check_reg(6'h24, 32'h0, "unmapped offset 0x24");
    end_test("reset values");

    begin_test();
    reg_write(REG_SRC, 32'h1234_5678);
    reg_write(REG_DST, 32'h9ABC_DEF0);
    reg_write(REG_NUM_BYTES, 32'h0000_0100);
    reg_write(REG_SRC_STRIDE, 32'h0000_0040);
    reg_write(REG_DST_STRIDE, 32'hFFFF_FFC0);
    reg_write(REG_NUM_REPS, 32'h0000_0007);
    reg_write(REG_DONE, 32'hDEAD_BEEF);
    check_reg(REG_SRC, 32'h1234_5678, "REG_SRC");
    check_reg(REG_DST, 32'h9ABC_DEF0, "REG_DST");
    check_reg(REG_NUM_BYTES, 32'h0000_0100, "REG_NUM_BYTES");
    check_reg(REG_SRC_STRIDE, 32'h0000_0040, "REG_SRC_STRIDE");
    check_reg(REG_DST_STRIDE, 32'hFFFF_FFC0, "REG_DST_STRIDE");
    check_reg(REG_NUM_REPS, 32'h0000_0007, "REG_NUM_REPS");
    check_reg(REG_DONE, 32'h0, "REG_DONE");
    end_test("register readback");

    // Zero reps runs one row of 16 words
    begin_test();
    start_copy(32'h000, 32'h400, 32'd64, 32'h0, 32'h0, 32'h0);
    finish_copy();
    end_test("1d copy");

    // 3 rows of 4 words with destination gaps kept at their preset
    begin_test();
    start_copy(32'h100, 32'h600, 32'd16, 32'h40, 32'h30, 32'd3);
    finish_copy();
    end_test("2d strided copy");

    begin_test();
    start_copy(32'h200, 32'h800, 32'd32, 32'h0, 32'h0, 32'h0);
    check_value("busy_o", 32'(busy), 32'h1);
    reg_read(REG_NEXT_ID, rd_val);
    check_value("REG_NEXT_ID while busy", rd_val, 32'h0);
    reg_read(REG_STATUS, rd_val);
    check_value("REG_STATUS", rd_val, 32'h1);
    check_value("busy_o", 32'(busy), 32'h1);
    finish_copy();
    start_copy(32'h280, 32'h880, 32'd16, 32'h20, 32'h40, 32'd2);
    finish_copy();
    end_test("ids and busy launch");

    $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
             test_count, failed_tests, check_count, total_errors());
    if (total_errors() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model import dma_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  mem_req_t mem_req_i,
  output mem_rsp_t mem_rsp_o
);

  localparam int unsigned MEM_WORDS  = 1024;
  localparam int unsigned STALL_SEED = 32'h92de;

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
  int unsigned           wait_cnt;
  logic                  rvalid_q;
  logic [DATA_WIDTH-1:0] rdata_q;

  // Grant once the drawn stall count has run out
  assign mem_rsp_o.gnt    = mem_req_i.req && (wait_cnt == 0);
  assign mem_rsp_o.rvalid = rvalid_q;
  assign mem_rsp_o.rdata  = rdata_q;

  // Preset word built from the full byte address
  function automatic logic [DATA_WIDTH-1:0] fill_word(input int unsigned idx);
    logic [31:0] byte_addr;
    byte_addr = idx * 4;
    return (byte_addr * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
  endfunction

  initial begin
    int unsigned i;
    rvalid_q = 1'b0;
    rdata_q  = '0;
    wait_cnt = 0;
    void'($urandom(STALL_SEED));
    for (i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end
    forever begin
      @(posedge clk_i);
      if (!rst_n_i) begin
        rvalid_q <= 1'b0;
        wait_cnt <= $urandom % 4;
      end else begin
        rvalid_q <= mem_rsp_o.gnt && !mem_req_i.we;
        if (mem_rsp_o.gnt && !mem_req_i.we) begin
          rdata_q <= mem[mem_req_i.addr[11:2]];
        end
        if (mem_rsp_o.gnt && mem_req_i.we) begin
          mem[mem_req_i.addr[11:2]] = mem_req_i.wdata;
        end
        // Count down while stalled and draw anew otherwise
        if (mem_req_i.req && !mem_rsp_o.gnt) begin
          wait_cnt <= wait_cnt - 1;
        end else begin
          wait_cnt <= $urandom % 4;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int unsigned HALF_PERIOD_NS = 4;
  localparam int unsigned RESET_CYCLES   = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Reset held over four rising edges, released between edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: source/dmac_top.sv
`timescale 1ns/1ps
`default_nettype none

module dmac_top import dma_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  ctrl_req_t ctrl_req_i,
  output ctrl_rsp_t ctrl_rsp_o,
  output mem_req_t  mem_req_o,
  input  mem_rsp_t  mem_rsp_i,
  output logic      term_event_o,
  output logic      busy_o
);

  xfer_desc_t            desc;
  logic                  start;
  logic [ADDR_WIDTH-1:0] src_addr;
  logic [ADDR_WIDTH-1:0] dst_addr;
  logic                  src_last;
  logic                  src_advance;
  logic                  dst_advance;

  // ------------------------------------------------------------------------
  // Frontend
  // ------------------------------------------------------------------------

  dma_reg_frontend i_frontend (
    .clk_i      ( clk_i        ),
    .rst_n_i    ( rst_n_i      ),
    .ctrl_req_i ( ctrl_req_i   ),
    .ctrl_rsp_o ( ctrl_rsp_o   ),
    .busy_i     ( busy_o       ),
    .done_i     ( term_event_o ),
    .desc_o     ( desc         ),
    .start_o    ( start        )
  );

  // ------------------------------------------------------------------------
  // Source and destination walks
  // ------------------------------------------------------------------------

  dma_addr_gen i_src_walk (
    .clk_i       ( clk_i           ),
    .rst_n_i     ( rst_n_i         ),
    .start_i     ( start           ),
    .base_i      ( desc.src        ),
    .stride_i    ( desc.src_stride ),
    .num_bytes_i ( desc.num_bytes  ),
    .num_reps_i  ( desc.num_reps   ),
    .advance_i   ( src_advance     ),
    .addr_o      ( src_addr        ),
    .last_o      ( src_last        )
  );

  // Same count as the source walk, its last flag is not needed
  dma_addr_gen i_dst_walk (
    .clk_i       ( clk_i           ),
    .rst_n_i     ( rst_n_i         ),
    .start_i     ( start           ),
    .base_i      ( desc.dst        ),
    .stride_i    ( desc.dst_stride ),
    .num_bytes_i ( desc.num_bytes  ),
    .num_reps_i  ( desc.num_reps   ),
    .advance_i   ( dst_advance     ),
    .addr_o      ( dst_addr        ),
    .last_o      (                 )
  );

  // ------------------------------------------------------------------------
  // Copy engine
  // ------------------------------------------------------------------------

  dma_copy_engine i_engine (
    .clk_i         ( clk_i        ),
    .rst_n_i       ( rst_n_i      ),
    .start_i       ( start        ),
    .src_addr_i    ( src_addr     ),
    .dst_addr_i    ( dst_addr     ),
    .last_i        ( src_last     ),
    .src_advance_o ( src_advance  ),
    .dst_advance_o ( dst_advance  ),
    .mem_req_o     ( mem_req_o    ),
    .mem_rsp_i     ( mem_rsp_i    ),
    .busy_o        ( busy_o       ),
    .done_o        ( term_event_o )
  );

endmodule

`default_nettype wire

// File: source/dma_copy_engine.sv
`timescale 1ns/1ps
`default_nettype none

module dma_copy_engine import dma_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  start_i,
  input  logic [ADDR_WIDTH-1:0] src_addr_i,
  input  logic [ADDR_WIDTH-1:0] dst_addr_i,
  input  logic                  last_i,
  output logic                  src_advance_o,
  output logic                  dst_advance_o,
  output mem_req_t              mem_req_o,
  input  mem_rsp_t              mem_rsp_i,
  output logic                  busy_o,
  output logic                  done_o
);

  engine_state_e         state_q;
  engine_state_e         state_d;
  logic [DATA_WIDTH-1:0] data_q;
  logic                  done_q;
  logic                  write_done;

  // Granted write retires the current word
  assign write_done = (state_q == ST_WRITE) && mem_rsp_i.gnt;

  // ------------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_READ;
        end
      end
      ST_READ: begin
        if (mem_rsp_i.gnt) begin
          state_d = ST_WAIT_DATA;
        end
      end
      ST_WAIT_DATA: begin
        if (mem_rsp_i.rvalid) begin
          state_d = ST_WRITE;
        end
      end
      ST_WRITE: begin
        if (mem_rsp_i.gnt) begin
          state_d = last_i ? ST_IDLE : ST_READ;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= write_done && last_i;
    end
  end

  // Word buffer between read and write
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_WAIT_DATA) && mem_rsp_i.rvalid) begin
      data_q <= mem_rsp_i.rdata;
    end
  end

  // ------------------------------------------------------------------------
  // Memory port
  // ------------------------------------------------------------------------

  // Address only moves on a write grant, so the request holds while stalled
  always_comb begin
    mem_req_o.req   = (state_q == ST_READ) || (state_q == ST_WRITE);
    mem_req_o.we    = (state_q == ST_WRITE);
    mem_req_o.addr  = (state_q == ST_WRITE) ? dst_addr_i : src_addr_i;
    mem_req_o.wdata = data_q;
  end

  // Both walks step together
  assign src_advance_o = write_done;
  assign dst_advance_o = write_done;

  assign busy_o = (state_q != ST_IDLE);
  assign done_o = done_q;

endmodule

`default_nettype wire

// File: source/dma_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module dma_addr_gen import dma_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  start_i,
  input  logic [ADDR_WIDTH-1:0] base_i,
  input  logic [ADDR_WIDTH-1:0] stride_i,
  input  logic [DATA_WIDTH-1:0] num_bytes_i,
  input  logic [DATA_WIDTH-1:0] num_reps_i,
  input  logic                  advance_i,
  output logic [ADDR_WIDTH-1:0] addr_o,
  output logic                  last_o
);

  logic [ADDR_WIDTH-1:0] row_base_q;
  logic [ADDR_WIDTH-1:0] stride_q;
  logic [ADDR_WIDTH-1:0] word_off_q;
  logic [ADDR_WIDTH-1:0] last_off_q;
  logic [DATA_WIDTH-1:0] row_cnt_q;
  logic [DATA_WIDTH-1:0] last_row_q;
  logic                  row_end;
  logic                  final_row;

  assign row_end   = (word_off_q == last_off_q);
  assign final_row = (row_cnt_q == last_row_q);
  assign addr_o    = row_base_q + word_off_q;
  assign last_o    = row_end & final_row;

  // Position within the walk
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      word_off_q <= '0;
      row_cnt_q  <= '0;
    end else if (start_i) begin
      word_off_q <= '0;
      row_cnt_q  <= '0;
    end else if (advance_i) begin
      if (row_end) begin
        word_off_q <= '0;
        row_cnt_q  <= row_cnt_q + 1'b1;
      end else begin
        word_off_q <= word_off_q + WORD_BYTES;
      end
    end
  end

  // Row base moves by one stride at each row end
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      row_base_q <= base_i;
      stride_q   <= stride_i;
      last_off_q <= num_bytes_i - WORD_BYTES;
      // Zero reps runs one row
      last_row_q <= (num_reps_i == '0) ? '0 : num_reps_i - 1'b1;
    end else if (advance_i && row_end) begin
      row_base_q <= row_base_q + stride_q;
    end
  end

endmodule

`default_nettype wire

// File: source/dma_reg_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module dma_reg_frontend import dma_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  ctrl_req_t  ctrl_req_i,
  output ctrl_rsp_t  ctrl_rsp_o,
  input  logic       busy_i,
  input  logic       done_i,
  output xfer_desc_t desc_o,
  output logic       start_o
);

  // Configuration fields, id field holds the running transfer
  xfer_desc_t            cfg_q;
  logic [ID_WIDTH-1:0]   next_id_q;
  logic [ID_WIDTH-1:0]   done_id_q;
  logic                  rvalid_q;
  logic [DATA_WIDTH-1:0] rdata_q;
  logic [DATA_WIDTH-1:0] rdata_d;
  reg_offset_e           offset;
  logic                  rd_access;
  logic                  wr_access;

  assign offset    = reg_offset_e'(ctrl_req_i.addr);
  assign wr_access = ctrl_req_i.req & ctrl_req_i.we;
  assign rd_access = ctrl_req_i.req & ~ctrl_req_i.we;

  // A NEXT_ID read while idle launches the transfer
  assign start_o = rd_access && (offset == REG_NEXT_ID) && !busy_i;

  // ------------------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------------------

  always_comb begin
    rdata_d = '0;
    case (offset)
      REG_SRC:        rdata_d = cfg_q.src;
      REG_DST:        rdata_d = cfg_q.dst;
      REG_NUM_BYTES:  rdata_d = cfg_q.num_bytes;
      REG_SRC_STRIDE: rdata_d = cfg_q.src_stride;
      REG_DST_STRIDE: rdata_d = cfg_q.dst_stride;
      REG_NUM_REPS:   rdata_d = cfg_q.num_reps;
      REG_NEXT_ID: begin
        // Rejected launch reads back 0
        if (start_o) begin
          rdata_d = {{(DATA_WIDTH-ID_WIDTH){1'b0}}, next_id_q};
        end
      end
      REG_DONE:       rdata_d = {{(DATA_WIDTH-ID_WIDTH){1'b0}}, done_id_q};
      REG_STATUS:     rdata_d = {{(DATA_WIDTH-1){1'b0}}, busy_i};
      default:        rdata_d = '0;
    endcase
  end

  // Every request granted in its own cycle
  assign ctrl_rsp_o.gnt    = ctrl_req_i.req;
  assign ctrl_rsp_o.rvalid = rvalid_q;
  assign ctrl_rsp_o.rdata  = rdata_q;

  // ------------------------------------------------------------------------
  // Register file and id tracking
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q     <= '0;
      next_id_q <= ID_WIDTH'(1);
      done_id_q <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      rvalid_q <= rd_access;
      if (wr_access) begin
        case (offset)
          REG_SRC:        cfg_q.src        <= ctrl_req_i.wdata;
          REG_DST:        cfg_q.dst        <= ctrl_req_i.wdata;
          REG_NUM_BYTES:  cfg_q.num_bytes  <= ctrl_req_i.wdata;
          REG_SRC_STRIDE: cfg_q.src_stride <= ctrl_req_i.wdata;
          REG_DST_STRIDE: cfg_q.dst_stride <= ctrl_req_i.wdata;
          REG_NUM_REPS:   cfg_q.num_reps   <= ctrl_req_i.wdata;
          default: ;
        endcase
      end
      if (start_o) begin
        cfg_q.id <= next_id_q;
        // Id 0 means rejected, so the counter skips it on wrap
        next_id_q <= (next_id_q == '1) ? ID_WIDTH'(1) : next_id_q + 1'b1;
      end
      if (done_i) begin
        done_id_q <= cfg_q.id;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_access) begin
      rdata_q <= rdata_d;
    end
  end

  // Id of the new transfer already visible with the start pulse
  always_comb begin
    desc_o = cfg_q;
    if (start_o) begin
      desc_o.id = next_id_q;
    end
  end

endmodule

`default_nettype wire

// File: source/dma_pkg.sv
`default_nettype none

package dma_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------

  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned WORD_BYTES     = 4;
  localparam int unsigned ID_WIDTH       = 28;
  localparam int unsigned REG_ADDR_WIDTH = 6;

  // ------------------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------------------

  // Byte offsets on the control port
  typedef enum logic [REG_ADDR_WIDTH-1:0] {
    REG_SRC        = 6'h00,
    REG_DST        = 6'h04,
    REG_NUM_BYTES  = 6'h08,
    REG_SRC_STRIDE = 6'h0C,
    REG_DST_STRIDE = 6'h10,
    REG_NUM_REPS   = 6'h14,
    REG_NEXT_ID    = 6'h18,
    REG_DONE       = 6'h1C,
    REG_STATUS     = 6'h20
  } reg_offset_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WAIT_DATA,
    ST_WRITE
  } engine_state_e;

  // ------------------------------------------------------------------------
  // Descriptor and bus structs
  // ------------------------------------------------------------------------

  // One 2D transfer; num_reps of 0 runs a single row
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] src;
    logic [ADDR_WIDTH-1:0] dst;
    logic [DATA_WIDTH-1:0] num_bytes;
    logic [ADDR_WIDTH-1:0] src_stride;
    logic [ADDR_WIDTH-1:0] dst_stride;
    logic [DATA_WIDTH-1:0] num_reps;
    logic [ID_WIDTH-1:0]   id;
  } xfer_desc_t;

  // Core side register port
  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [REG_ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]     wdata;
  } ctrl_req_t;

  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [DATA_WIDTH-1:0] rdata;
  } ctrl_rsp_t;

  // Memory side, req/gnt/rvalid strobes
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [DATA_WIDTH-1:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire
